//--- tb.f
+incdir+rtl
rtl/csb_cmd_pkg.sv
rtl/csb_data_pkg.sv
rtl/csb_cmd_decoder.sv
rtl/csb_addr_gen.sv
rtl/csb_window_packer.sv
rtl/csb_mac_engine.sv
rtl/csb_top.sv
verification/csb_clk_gen.sv
verification/csb_assert.sv
verification/csb_tb.sv

//--- Makefile
SIM      := verilator
TOP      := csb_tb
FILELIST := tb.f
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
RUN_ARGS := +verilator+error+limit+100
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/csb_tb.sv
`timescale 1ns/1ns
`include "csb_defines.svh"

module csb_tb;

    localparam int TIMEOUT = 4000;   // Cycles allowed per irq wait

    logic                   clk;
    logic                   rst;
    logic                   cmd_fifo_empty;
    logic [`CSB_WORD_W-1:0] cmd;
    logic                   cmd_fifo_rd_en;
    logic                   im_fifo_empty;
    logic                   iwb_fifo_empty;
    logic [`CSB_WORD_W-1:0] data;
    logic [`CSB_WORD_W-1:0] weightbias;
    logic                   im_fifo_rd_en;
    logic                   iwb_fifo_rd_en;
    logic                   dma_aux_we;
    csb_data_pkg::result_t  result;
    logic [`CSB_WORD_W-1:0] r_addr;
    logic [`CSB_WORD_W-1:0] wb_addr;
    logic                   irq;

    logic [`CSB_WORD_W-1:0] cmd_q [$];
    logic [`CSB_WORD_W-1:0] data_q [$];
    logic [`CSB_WORD_W-1:0] wb_q [$];
    csb_data_pkg::result_t  exp_q [$];
    int                     outs_q [$];     // out_cnt of each loaded job
    bit                     stall_en;
    int                     irq_cnt;
    int                     job_results;    // Results seen since the last irq
    logic                   take_cmd;
    logic                   take_im;
    logic                   take_wb;

    csb_clk_gen #(.PERIOD(8)) clk_inst (.clk(clk));

    csb_top csb_top_inst (.*);

    bind csb_top csb_assert assert_inst (
        .clk(clk), .rst(rst), .cmd_fifo_empty(cmd_fifo_empty),
        .cmd_fifo_rd_en(cmd_fifo_rd_en), .im_fifo_empty(im_fifo_empty),
        .im_fifo_rd_en(im_fifo_rd_en), .iwb_fifo_empty(iwb_fifo_empty),
        .iwb_fifo_rd_en(iwb_fifo_rd_en), .dma_aux_we(dma_aux_we), .irq(irq),
        .job_active(job_active), .job_start(job_start), .r_addr(r_addr),
        .wb_addr(wb_addr),
        .win_valid_1x1(win_valid_1x1), .win_valid_3x3(win_valid_3x3),
        .credits_1x1(pack_1x1.credits), .credits_3x3(pack_3x3.credits)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on a failure");
    endtask

    function automatic bit stall_now();
        return stall_en && ($urandom_range(3) == 0);   // Roughly one cycle in four
    endfunction

    // Command words, FIFO contents in stream order, and expected results
    task automatic load_job(input csb_cmd_pkg::op_e op, input int in_ch, input int out_cnt,
                            input logic [31:0] w_base, input logic [31:0] d_base,
                            input logic [31:0] wb_base);
        int                    ksize;
        logic [31:0]           word;
        logic signed [15:0]    bias;
        logic signed [15:0]    smp;
        logic signed [15:0]    wgt;
        longint                acc;
        csb_data_pkg::result_t expected;
        ksize = (op == csb_cmd_pkg::OP_CONV3X3) ? 9 : 1;
        cmd_q.push_back({24'h0, op});
        cmd_q.push_back({out_cnt[15:0], in_ch[15:0]});
        cmd_q.push_back(w_base);
        cmd_q.push_back(d_base);
        cmd_q.push_back(wb_base);
        for (int o = 0; o < out_cnt; o++) begin
            word = $urandom;                  // Upper half is noise
            wb_q.push_back(word);
            bias = word[15:0];
            acc  = longint'(bias);
            for (int c = 0; c < in_ch; c++) begin
                for (int k = 0; k < ksize; k++) begin
                    word = $urandom;
                    data_q.push_back(word);
                    smp  = word[15:0];
                    word = $urandom;
                    wb_q.push_back(word);
                    wgt  = word[15:0];
                    acc  = acc + longint'(smp) * longint'(wgt);
                end
            end
            expected.value = acc[39:0];
            expected.addr  = wb_base + o;
            exp_q.push_back(expected);
        end
        outs_q.push_back(out_cnt);
    endtask

    task automatic wait_for_irqs(input int target);
        int cycles;
        cycles = 0;
        while (irq_cnt < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run($sformatf("Timed out waiting for irq number %0d", target));
            end
        end
    endtask

    task automatic check_result();
        csb_data_pkg::result_t expected;
        if (exp_q.size() == 0) begin
            abort_run("A result was written while none was expected");
        end else begin
            expected = exp_q.pop_front();
            job_results++;
            result_ok: assert (result == expected) else begin
                abort_run($sformatf("[ERROR] %0t: got %0d at 0x%08h, want %0d at 0x%08h",
                    $time, $signed(result.value), result.addr,
                    $signed(expected.value), expected.addr));
            end
        end
    endtask

    task automatic close_job();
        int want;
        irq_cnt++;
        if (outs_q.size() == 0) begin
            abort_run("irq was raised with no job loaded");
        end else begin
            want = outs_q.pop_front();
            job_count_ok: assert (job_results == want) else begin
                abort_run($sformatf("[ERROR] %0t: job ended after %0d results, want %0d",
                    $time, job_results, want));
            end
            job_results = 0;
        end
    endtask

    // FIFO models with one cycle of read latency
    always begin
        @(negedge clk);
        take_cmd = cmd_fifo_rd_en;
        take_im  = im_fifo_rd_en;
        take_wb  = iwb_fifo_rd_en;
        @(posedge clk);
        #1;
        if (take_cmd) begin
            cmd = cmd_q.pop_front();
        end
        if (take_im) begin
            data = data_q.pop_front();
        end
        if (take_wb) begin
            weightbias = wb_q.pop_front();
        end
        cmd_fifo_empty = (cmd_q.size() == 0) || stall_now();
        im_fifo_empty  = (data_q.size() == 0) || stall_now();
        iwb_fifo_empty = (wb_q.size() == 0) || stall_now();
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (csb_top_inst.assert_inst.fail_cnt != 0) begin
                abort_run("A protocol assertion on the DUT failed");
            end
            if (dma_aux_we) begin
                check_result();
            end
            if (irq) begin
                close_job();
            end
        end
    end

    initial begin
        rst            = 1'b1;
        cmd_fifo_empty = 1'b1;
        im_fifo_empty  = 1'b1;
        iwb_fifo_empty = 1'b1;
        cmd            = '0;
        data           = '0;
        weightbias     = '0;
        stall_en       = 1'b0;
        irq_cnt        = 0;
        job_results    = 0;
        void'($urandom(24));
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        load_job(csb_cmd_pkg::OP_CONV1X1, 3, 4, 32'h0000_1000, 32'h0000_2000, 32'h0000_3000);
        wait_for_irqs(1);
        stall_en = 1'b1;     // Random empty flags from here on
        @(negedge clk);
        load_job(csb_cmd_pkg::OP_CONV3X3, 2, 3, 32'h0000_4000, 32'h0000_5000, 32'h0000_6000);
        wait_for_irqs(2);
        @(negedge clk);
        load_job(csb_cmd_pkg::OP_CONV1X1, 3, 4, 32'h0001_0000, 32'h0002_0000, 32'h0003_0000);
        load_job(csb_cmd_pkg::OP_CONV3X3, 2, 3, 32'h0004_0000, 32'h0005_0000, 32'h0006_0000);
        wait_for_irqs(4);
        repeat (4) @(posedge clk);
        if (exp_q.size() == 0 && cmd_q.size() == 0 &&
            csb_top_inst.assert_inst.fail_cnt == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run("The run ended with results or commands left over");
        end
    end

endmodule

//--- verification/csb_assert.sv
`timescale 1ns/1ns
`include "csb_defines.svh"

module csb_assert (
    input logic                                   clk,
    input logic                                   rst,
    input logic                                   cmd_fifo_empty,
    input logic                                   cmd_fifo_rd_en,
    input logic                                   im_fifo_empty,
    input logic                                   im_fifo_rd_en,
    input logic                                   iwb_fifo_empty,
    input logic                                   iwb_fifo_rd_en,
    input logic                                   dma_aux_we,
    input logic                                   irq,
    input logic                                   job_active,
    input logic                                   job_start,
    input logic [`CSB_WORD_W-1:0]                 r_addr,
    input logic [`CSB_WORD_W-1:0]                 wb_addr,
    input logic                                   win_valid_1x1,
    input logic                                   win_valid_3x3,
    input logic [$clog2(`CSB_CREDITS + 1)-1:0]    credits_1x1,
    input logic [$clog2(`CSB_CREDITS + 1)-1:0]    credits_3x3
);

    localparam int AW = `CSB_WORD_W;

    int unsigned fail_cnt = 0;   // Failed assertions so far

    cmd_rd_ok: assert property (@(posedge clk) disable iff (rst)
        !(cmd_fifo_rd_en && cmd_fifo_empty))
    else begin
        fail_cnt++;
        $error("Command FIFO read while empty");
    end

    stream_rd_ok: assert property (@(posedge clk) disable iff (rst)
        !(im_fifo_rd_en && im_fifo_empty) && !(iwb_fifo_rd_en && iwb_fifo_empty))
    else begin
        fail_cnt++;
        $error("Data or weight FIFO read while empty");
    end

    credit_range: assert property (@(posedge clk) disable iff (rst)
        credits_1x1 <= `CSB_CREDITS && credits_3x3 <= `CSB_CREDITS)
    else begin
        fail_cnt++;
        $error("Packer credit count out of range");
    end

    credit_spent: assert property (@(posedge clk) disable iff (rst)
        (!win_valid_1x1 || $past(credits_1x1) != '0) &&
        (!win_valid_3x3 || $past(credits_3x3) != '0))
    else begin
        fail_cnt++;
        $error("Window sent without a credit");
    end

    irq_pulse: assert property (@(posedge clk) disable iff (rst) irq |=> !irq)
    else begin
        fail_cnt++;
        $error("irq held longer than one cycle");
    end

    irq_after_result: assert property (@(posedge clk) disable iff (rst)
        irq |-> $past(dma_aux_we))
    else begin
        fail_cnt++;
        $error("irq not right after the last result");
    end

    result_in_job: assert property (@(posedge clk) disable iff (rst) dma_aux_we |-> job_active)
    else begin
        fail_cnt++;
        $error("Result written outside a job");
    end

    // Outside job start each address steps by its own stream reads
    r_addr_step: assert property (@(posedge clk) disable iff (rst)
        !job_start |=> r_addr == $past(r_addr) + AW'($past(im_fifo_rd_en)))
    else begin
        fail_cnt++;
        $error("r_addr did not follow the data reads");
    end

    wb_addr_step: assert property (@(posedge clk) disable iff (rst)
        !job_start |=> wb_addr == $past(wb_addr) + AW'($past(iwb_fifo_rd_en)))
    else begin
        fail_cnt++;
        $error("wb_addr did not follow the weight reads");
    end

    reset_quiet: assert property (@(posedge clk)
        rst |=> !irq && !dma_aux_we && !job_active && !cmd_fifo_rd_en &&
                !im_fifo_rd_en && !iwb_fifo_rd_en &&
                !win_valid_1x1 && !win_valid_3x3 &&
                credits_1x1 == `CSB_CREDITS && credits_3x3 == `CSB_CREDITS)
    else begin
        fail_cnt++;
        $error("Control outputs not idle after reset");
    end

endmodule

//--- verification/csb_clk_gen.sv
`timescale 1ns/1ns

module csb_clk_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;   // Free running, no enable
    end

endmodule

//--- rtl/csb_top.sv
`timescale 1ns/1ns
`include "csb_defines.svh"

module csb_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_fifo_empty,
    input  logic [`CSB_WORD_W-1:0] cmd,
    output logic                   cmd_fifo_rd_en,
    input  logic                   im_fifo_empty,
    input  logic                   iwb_fifo_empty,
    input  logic [`CSB_WORD_W-1:0] data,
    input  logic [`CSB_WORD_W-1:0] weightbias,
    output logic                   im_fifo_rd_en,
    output logic                   iwb_fifo_rd_en,
    output logic                   dma_aux_we,
    output csb_data_pkg::result_t  result,
    output logic [`CSB_WORD_W-1:0] r_addr,
    output logic [`CSB_WORD_W-1:0] wb_addr,
    output logic                   irq
);

    csb_cmd_pkg::job_t      job;
    logic                   job_active;
    logic                   job_active_q;
    logic                   job_start;
    logic [`CSB_WORD_W-1:0] w_addr;
    logic                   sel_3x3;
    logic                   en_1x1;
    logic                   en_3x3;
    logic                   im_rd_1x1, iwb_rd_1x1;
    logic                   im_rd_3x3, iwb_rd_3x3;
    csb_data_pkg::win1_t    win_1x1;
    csb_data_pkg::win9_t    win_3x3;
    logic                   win_valid_1x1, win_valid_3x3;
    logic                   credit_1x1, credit_3x3;
    csb_data_pkg::result_t  result_1x1, result_3x3;
    logic                   res_valid_1x1, res_valid_3x3;
    logic                   result_valid;

    assign sel_3x3   = (job.op == csb_cmd_pkg::OP_CONV3X3);
    assign en_1x1    = job_active && (job.op == csb_cmd_pkg::OP_CONV1X1);
    assign en_3x3    = job_active && sel_3x3;
    assign job_start = job_active && !job_active_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            job_active_q <= 1'b0;
        end else begin
            job_active_q <= job_active;
        end
    end

    // Only the selected packer ever reads
    assign im_fifo_rd_en  = sel_3x3 ? im_rd_3x3 : im_rd_1x1;
    assign iwb_fifo_rd_en = sel_3x3 ? iwb_rd_3x3 : iwb_rd_1x1;
    assign result_valid   = res_valid_1x1 || res_valid_3x3;
    assign result         = sel_3x3 ? result_3x3 : result_1x1;
    assign dma_aux_we     = result_valid;  // Result write strobe

    csb_cmd_decoder dec_inst (
        .clk(clk), .rst(rst), .cmd_fifo_empty(cmd_fifo_empty), .cmd(cmd),
        .cmd_fifo_rd_en(cmd_fifo_rd_en), .result_valid(result_valid), .job(job),
        .job_active(job_active), .irq(irq)
    );

    csb_addr_gen addr_inst (
        .clk(clk), .rst(rst), .job(job), .job_start(job_start), .data_rd(im_fifo_rd_en),
        .wb_rd(iwb_fifo_rd_en), .r_addr(r_addr), .wb_addr(wb_addr), .w_addr(w_addr),
        .result_valid(result_valid)
    );

    csb_window_packer #(.WIN_T(csb_data_pkg::win1_t), .KSIZE(csb_data_pkg::K1X1)) pack_1x1 (
        .clk(clk), .rst(rst), .enable(en_1x1), .in_ch(job.in_ch), .out_cnt(job.out_cnt),
        .im_fifo_empty(im_fifo_empty), .iwb_fifo_empty(iwb_fifo_empty), .data(data),
        .weightbias(weightbias), .im_fifo_rd_en(im_rd_1x1), .iwb_fifo_rd_en(iwb_rd_1x1),
        .win(win_1x1), .win_valid(win_valid_1x1), .credit_ret(credit_1x1)
    );

    csb_mac_engine #(.WIN_T(csb_data_pkg::win1_t), .KSIZE(csb_data_pkg::K1X1)) mac_1x1 (
        .clk(clk), .rst(rst), .win(win_1x1), .win_valid(win_valid_1x1),
        .credit_ret(credit_1x1), .w_addr(w_addr), .result(result_1x1),
        .result_valid(res_valid_1x1)
    );

    csb_window_packer #(.WIN_T(csb_data_pkg::win9_t), .KSIZE(csb_data_pkg::K3X3)) pack_3x3 (
        .clk(clk), .rst(rst), .enable(en_3x3), .in_ch(job.in_ch), .out_cnt(job.out_cnt),
        .im_fifo_empty(im_fifo_empty), .iwb_fifo_empty(iwb_fifo_empty), .data(data),
        .weightbias(weightbias), .im_fifo_rd_en(im_rd_3x3), .iwb_fifo_rd_en(iwb_rd_3x3),
        .win(win_3x3), .win_valid(win_valid_3x3), .credit_ret(credit_3x3)
    );

    csb_mac_engine #(.WIN_T(csb_data_pkg::win9_t), .KSIZE(csb_data_pkg::K3X3)) mac_3x3 (
        .clk(clk), .rst(rst), .win(win_3x3), .win_valid(win_valid_3x3),
        .credit_ret(credit_3x3), .w_addr(w_addr), .result(result_3x3),
        .result_valid(res_valid_3x3)
    );

endmodule

//--- rtl/csb_mac_engine.sv
`timescale 1ns/1ns
`include "csb_defines.svh"

module csb_mac_engine #(
    parameter type WIN_T = csb_data_pkg::win1_t,
    parameter int  KSIZE = 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  WIN_T                   win,
    input  logic                   win_valid,
    output logic                   credit_ret,
    input  logic [`CSB_WORD_W-1:0] w_addr,
    output csb_data_pkg::result_t  result,
    output logic                   result_valid
);

    localparam int DEPTH = `CSB_CREDITS;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    WIN_T                 fifo_mem [DEPTH];
    logic [PW-1:0]        wr_ptr;
    logic [PW-1:0]        rd_ptr;
    logic [CW-1:0]        fill;
    logic                 pop;

    logic                 s1_valid;
    WIN_T                 s1_win;
    csb_data_pkg::acc_t   mul [KSIZE];
    logic                 s2_valid;
    csb_data_pkg::acc_t   s2_prod [KSIZE];
    csb_data_pkg::acc_t   s2_bias;
    logic                 s2_last;
    logic                 first;      // Next window opens a new output
    csb_data_pkg::acc_t   acc;
    csb_data_pkg::acc_t   acc_sum;
    csb_data_pkg::acc_t   res_value;

    // Pipeline takes one window per cycle
    assign pop        = (fill != '0);
    assign credit_ret = pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fill         <= '0;
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
            first        <= 1'b1;
        end else begin
            if (win_valid) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill         <= fill + CW'(win_valid) - CW'(pop);
            s1_valid     <= pop;
            s2_valid     <= s1_valid;
            result_valid <= s2_valid && s2_last;
            if (s2_valid) begin
                first <= s2_last;
            end
        end
    end

    // Products of the KSIZE pairs
    always_comb begin
        for (int i = 0; i < KSIZE; i++) begin
            mul[i] = $signed(s1_win.data[i]) * $signed(s1_win.weight[i]);
        end
    end

    // Bias seeds the first channel only
    always_comb begin
        acc_sum = first ? s2_bias : acc;
        for (int i = 0; i < KSIZE; i++) begin
            acc_sum = acc_sum + s2_prod[i];
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            fifo_mem[wr_ptr] <= win;
        end
        if (pop) begin
            s1_win <= fifo_mem[rd_ptr];        // Cycle N accept
        end
        if (s1_valid) begin
            s2_prod <= mul;                     // Multiply stage
            s2_bias <= $signed(s1_win.bias);
            s2_last <= s1_win.last;
        end
        if (s2_valid) begin
            acc <= acc_sum;                     // Accumulate stage
            if (s2_last) begin
                res_value <= acc_sum;
            end
        end
    end

    assign result.value = res_value;
    assign result.addr  = w_addr;

endmodule

//--- rtl/csb_window_packer.sv
`timescale 1ns/1ns
`include "csb_defines.svh"

module csb_window_packer #(
    parameter type WIN_T = csb_data_pkg::win1_t,
    parameter int  KSIZE = 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable,
    input  logic [15:0]            in_ch,
    input  logic [15:0]            out_cnt,
    input  logic                   im_fifo_empty,
    input  logic                   iwb_fifo_empty,
    input  logic [`CSB_WORD_W-1:0] data,
    input  logic [`CSB_WORD_W-1:0] weightbias,
    output logic                   im_fifo_rd_en,
    output logic                   iwb_fifo_rd_en,
    output WIN_T                   win,
    output logic                   win_valid,
    input  logic                   credit_ret
);

    localparam int KW = (KSIZE > 1) ? $clog2(KSIZE) : 1;
    localparam int CW = $clog2(`CSB_CREDITS + 1);

    typedef enum logic [2:0] {PH_BIAS, PH_DATA, PH_WGT, PH_SEND, PH_DONE} phase_e;

    phase_e        ph;
    logic          pend;        // FIFO word due next cycle
    logic [KW-1:0] k_idx;
    logic [15:0]   ch_idx;
    logic [15:0]   out_idx;
    logic [CW-1:0] credits;
    logic          has_credit;
    logic          send;
    logic          last_ch;

    assign has_credit = (credits != '0);
    assign last_ch    = (ch_idx == in_ch - 16'd1);
    assign send       = enable && (ph == PH_SEND) && has_credit;

    // No reads without a credit
    assign im_fifo_rd_en  = enable && has_credit && !pend && (ph == PH_DATA) && !im_fifo_empty;
    assign iwb_fifo_rd_en = enable && has_credit && !pend &&
                            (ph == PH_BIAS || ph == PH_WGT) && !iwb_fifo_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            ph        <= PH_BIAS;
            pend      <= 1'b0;
            k_idx     <= '0;
            ch_idx    <= '0;
            out_idx   <= '0;
            win_valid <= 1'b0;
            credits   <= CW'(`CSB_CREDITS);
        end else begin
            credits   <= credits - CW'(send) + CW'(credit_ret);
            win_valid <= send;
            if (!enable) begin
                ph      <= PH_BIAS;   // Fresh start for the next job
                pend    <= 1'b0;
                k_idx   <= '0;
                ch_idx  <= '0;
                out_idx <= '0;
            end else begin
                pend <= im_fifo_rd_en || iwb_fifo_rd_en;
                if (pend) begin
                    if (ph == PH_BIAS) begin
                        ph <= PH_DATA;
                    end else if (ph == PH_DATA) begin
                        ph <= PH_WGT;
                    end else if (k_idx == KW'(KSIZE - 1)) begin
                        k_idx <= '0;
                        ph    <= PH_SEND;    // Window complete
                    end else begin
                        k_idx <= k_idx + 1'b1;
                        ph    <= PH_DATA;
                    end
                end
                if (send) begin
                    if (last_ch) begin
                        ch_idx <= '0;
                        if (out_idx == out_cnt - 16'd1) begin
                            ph <= PH_DONE;
                        end else begin
                            out_idx <= out_idx + 16'd1;
                            ph      <= PH_BIAS;
                        end
                    end else begin
                        ch_idx <= ch_idx + 16'd1;
                        ph     <= PH_DATA;   // Bias stays for the next channel
                    end
                end
            end
        end
    end

    // Window contents
    always_ff @(posedge clk) begin
        if (pend && ph == PH_BIAS) begin
            win.bias <= weightbias[`CSB_SAMPLE_W-1:0];
        end else if (pend && ph == PH_DATA) begin
            win.data[k_idx] <= data[`CSB_SAMPLE_W-1:0];
        end else if (pend && ph == PH_WGT) begin
            win.weight[k_idx] <= weightbias[`CSB_SAMPLE_W-1:0];
        end
        if (send) begin
            win.last <= last_ch;
        end
    end

endmodule

//--- rtl/csb_addr_gen.sv
`timescale 1ns/1ns
`include "csb_defines.svh"

module csb_addr_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  csb_cmd_pkg::job_t      job,
    input  logic                   job_start,
    input  logic                   data_rd,
    input  logic                   wb_rd,
    output logic [`CSB_WORD_W-1:0] r_addr,
    output logic [`CSB_WORD_W-1:0] wb_addr,
    output logic [`CSB_WORD_W-1:0] w_addr,
    input  logic                   result_valid
);

    localparam int AW = `CSB_WORD_W;

    logic [AW-1:0] data_step;
    logic [AW-1:0] wb_step;
    logic [AW-1:0] res_step;

    assign data_step = AW'(data_rd);
    assign wb_step   = AW'(wb_rd);
    assign res_step  = AW'(result_valid);

    // Each address points at the next word of its stream
    always_ff @(posedge clk) begin
        if (rst) begin
            r_addr  <= '0;
            wb_addr <= '0;
            w_addr  <= '0;
        end else if (job_start) begin
            // A packer may read in the first job cycle
            r_addr  <= job.d_base + data_step;
            wb_addr <= job.w_base + wb_step;
            w_addr  <= job.wb_base;
        end else begin
            r_addr  <= r_addr + data_step;
            wb_addr <= wb_addr + wb_step;
            w_addr  <= w_addr + res_step;    // One slot per result
        end
    end

endmodule

//--- rtl/csb_cmd_decoder.sv
`timescale 1ns/1ns
`include "csb_defines.svh"

module csb_cmd_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_fifo_empty,
    input  logic [`CSB_WORD_W-1:0] cmd,
    output logic                   cmd_fifo_rd_en,
    input  logic                   result_valid,
    output csb_cmd_pkg::job_t      job,
    output logic                   job_active,
    output logic                   irq
);

    csb_cmd_pkg::cmd_idx_t word_idx;    // Next word to capture
    logic                  rd_pending;  // Word shows up one cycle after the read
    csb_cmd_pkg::cnt_t     res_cnt;     // Results seen in this job
    logic                  last_word;

    // Only fetch between jobs, one read in flight
    assign cmd_fifo_rd_en = !job_active && !rd_pending && !cmd_fifo_empty;
    assign last_word = (word_idx == csb_cmd_pkg::cmd_idx_t'(csb_cmd_pkg::CMD_WORDS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            word_idx   <= '0;
            rd_pending <= 1'b0;
            job_active <= 1'b0;
            res_cnt    <= '0;
            irq        <= 1'b0;
        end else begin
            irq        <= 1'b0;
            rd_pending <= cmd_fifo_rd_en;
            if (rd_pending) begin
                if (last_word) begin
                    word_idx   <= '0;
                    job_active <= 1'b1;     // All fields are in place now
                    res_cnt    <= '0;
                end else begin
                    word_idx <= word_idx + 3'd1;
                end
            end
            if (job_active && result_valid) begin
                if (res_cnt == job.out_cnt - 16'd1) begin
                    job_active <= 1'b0;     // Back to command fetch
                    irq        <= 1'b1;
                end else begin
                    res_cnt <= res_cnt + 16'd1;
                end
            end
        end
    end

    // Field capture from the word that just arrived
    always_ff @(posedge clk) begin
        if (rd_pending) begin
            case (word_idx)
                3'd0: job.op <= csb_cmd_pkg::op_e'(cmd[7:0]);
                3'd1: begin
                    job.in_ch   <= cmd[15:0];
                    job.out_cnt <= cmd[31:16];
                end
                3'd2: job.w_base  <= cmd;
                3'd3: job.d_base  <= cmd;
                3'd4: job.wb_base <= cmd;
                default: job <= job;
            endcase
        end
    end

endmodule

//--- rtl/csb_data_pkg.sv
`include "csb_defines.svh"

package csb_data_pkg;

    // Kernel window sizes
    localparam int K1X1 = 1;
    localparam int K3X3 = 9;

    typedef logic signed [`CSB_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`CSB_ACC_W-1:0]    acc_t;

    // Conv 1x1 window, one pair per channel
    typedef struct packed {
        sample_t            bias;
        sample_t [K1X1-1:0] data;
        sample_t [K1X1-1:0] weight;
        logic               last;   // Final input channel of this output
    } win1_t;

    // Conv 3x3 window, nine pairs per channel
    typedef struct packed {
        sample_t            bias;
        sample_t [K3X3-1:0] data;
        sample_t [K3X3-1:0] weight;
        logic               last;
    } win9_t;

    // One output value with its write-back address
    typedef struct packed {
        acc_t                   value;
        logic [`CSB_WORD_W-1:0] addr;
    } result_t;

endpackage

//--- rtl/csb_cmd_pkg.sv
`include "csb_defines.svh"

package csb_cmd_pkg;

    // Five words make up one command
    localparam int CMD_WORDS = 5;

    typedef logic [2:0]             cmd_idx_t;  // Word position inside a command
    typedef logic [15:0]            cnt_t;      // Channel and output counts
    typedef logic [`CSB_WORD_W-1:0] addr_t;

    // Op type, bits 7..0 of word 0
    typedef enum logic [7:0] {
        OP_CONV1X1 = 8'd1,
        OP_CONV3X3 = 8'd2
    } op_e;

    // Decoded job, held for the whole run
    typedef struct packed {
        op_e   op;
        cnt_t  in_ch;     // Word 1 low half
        cnt_t  out_cnt;   // Word 1 high half
        addr_t w_base;    // Word 2
        addr_t d_base;    // Word 3
        addr_t wb_base;   // Word 4
    } job_t;

endpackage

//--- rtl/csb_defines.svh
`ifndef CSB_DEFINES_SVH
`define CSB_DEFINES_SVH

// Host command words, FIFO words and addresses
`define CSB_WORD_W 32

// Signed sample, weight and bias width, taken from the low half of a word
`define CSB_SAMPLE_W 16

// Accumulator width
`define CSB_ACC_W 40

// Window slots in each engine input buffer
`define CSB_CREDITS 2

`endif
